// File: Makefile
# verilator build and run of the bit-manipulation unit testbench

VERILATOR ?= verilator
TOP       ?= bmuTb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= NO ERRORS
VFLAGS    ?= --binary -Wno-fatal

SOURCES := $(wildcard design/*.sv design/*.svh bench/*.sv)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run, search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP BUILD_DIR LOG PASS_TEXT VFLAGS"

$(BUILD_DIR)/V$(TOP): $(SOURCES) list.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f list.f --Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then echo "simulation passed"; \
	else echo "simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/bmuTb.sv
////////////////////////////////////////////////////////////////////////////
// bit-manipulation unit testbench
// replays the data file through both credit handshakes, checks results
// in issue order, the enables, the illegal counter and the stall
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "bmu_consts.svh"

module bmuTb import bmuPkg::*; ();

  localparam int waitLimit = 400;  // cycles per wait loop

  logic    clk;
  logic    rstN;
  logic    instrValid;
  instrT   instr;
  xlenT    srcA;
  xlenT    srcB;
  logic    instrCredit;
  logic    resultValid;
  xlenT    result;
  logic    illegal;
  logic    resultCredit;
  logic    cfgWrite;
  cfgAddrT cfgAddr;
  xlenT    cfgWdata;
  xlenT    cfgRdata;

  int          lineKind[$];   // parsed data file
  int          lineNo[$];
  int          lineIll[$];
  logic [31:0] lineWord[$];
  logic [31:0] lineA[$];
  logic [31:0] lineB[$];
  logic [31:0] lineRes[$];
  int          expQueue[$];   // data indices in issue order

  int senderCredits = `BMU_QUEUE_DEPTH;
  int issuedCount = 0;
  int resultsReceived = 0;
  int creditPulses = 0;       // instrCredit pulses seen
  int illTracked = 0;         // illegal lines issued per file flag
  int errorCount = 0;
  int testCount = 0;
  int creditGap = 0;          // idle cycles before next grant
  bit creditsOn = 1'b0;       // consumer grants withheld at start
  bit timedOut = 1'b0;
  int i;

  bmuTop dut0 (
    .clk, .rstN,
    .instrValid, .instr, .srcA, .srcB, .instrCredit,
    .resultValid, .result, .illegal, .resultCredit,
    .cfgWrite, .cfgAddr, .cfgWdata, .cfgRdata
  );

  always #10 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual, inout bit ok);
    if (expected !== actual) begin
      $display("error %s: expected %h, actual %h", name, expected, actual);
      errorCount++;
      ok = 1'b0;
    end
  endtask

  task automatic report(input string name, input bit ok);
    testCount++;
    $display("%s %s", name, ok ? "passed" : "failed");
  endtask

  task automatic timeoutHit(input string what);
    $display("timeout while waiting for %s", what);
    errorCount++;
    timedOut = 1'b1;
  endtask

  // advance one cycle and return last cycle's credit to the sender
  task tick();
    @(posedge clk);
    if (instrCredit) senderCredits++;
  endtask

  task automatic loadData();
    int          fd;
    int          n;
    int          lineNum;
    int          kind;
    int          flag;
    logic [31:0] word;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    string       text;
    lineNum = 0;
    fd = $fopen("bench/bmu_testdata.txt", "r");
    if (fd == 0) begin
      $display("cannot open bench/bmu_testdata.txt");
      errorCount++;
      return;
    end
    while (!$feof(fd)) begin
      text = "";
      void'($fgets(text, fd));
      lineNum++;
      if (text.len() < 2 || text.substr(0, 1) == "//") continue;  // blank or column notes
      n = $sscanf(text, "%d %h %h %h %h %d", kind, word, a, b, res, flag);
      if (n != 6) begin
        $display("data line %0d does not hold six fields", lineNum);
        errorCount++;
      end else begin
        lineKind.push_back(kind);
        lineNo.push_back(lineNum);
        lineWord.push_back(word);
        lineA.push_back(a);
        lineB.push_back(b);
        lineRes.push_back(res);
        lineIll.push_back(flag);
      end
    end
    $fclose(fd);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // sender, config access and drain
  ////////////////////////////////////////////////////////////////////////////

  task automatic sendInstr(input int idx);
    int waited;
    waited = 0;
    while (senderCredits == 0 && waited < waitLimit) begin
      instrValid <= 1'b0;                       // hold off without a credit
      tick();
      waited++;
    end
    if (senderCredits == 0) begin
      timeoutHit("an upstream credit");
    end else begin
      instrValid <= 1'b1;
      instr      <= lineWord[idx];
      srcA       <= lineA[idx];
      srcB       <= lineB[idx];
      senderCredits--;
      issuedCount++;
      if (lineIll[idx] != 0) illTracked++;
      expQueue.push_back(idx);
      tick();
    end
  endtask

  task automatic waitDrain();
    int waited;
    waited = 0;
    instrValid <= 1'b0;
    while (expQueue.size() != 0 && waited < waitLimit) begin
      tick();
      waited++;
    end
    if (expQueue.size() != 0) timeoutHit("outstanding results to drain");
  endtask

  task automatic writeEnable(input int idx);
    bit ok;
    ok = 1'b1;
    instrValid <= 1'b0;
    cfgWrite   <= 1'b1;
    cfgAddr    <= `CFG_ADDR_ENABLE;
    cfgWdata   <= lineWord[idx];
    tick();
    cfgWrite <= 1'b0;
    tick();                                     // read back the written register
    checkValue($sformatf("line %0d enables", lineNo[idx]), 32'(lineWord[idx][2:0]),
               cfgRdata, ok);
    report($sformatf("line %0d", lineNo[idx]), ok);
  endtask

  task automatic readIllCount(input int idx);
    bit ok;
    ok = 1'b1;
    waitDrain();                                // every op has entered the queue
    if (!timedOut) begin
      cfgAddr <= `CFG_ADDR_ILLCOUNT;
      tick();
      checkValue($sformatf("line %0d count", lineNo[idx]), illTracked, cfgRdata, ok);
      checkValue($sformatf("line %0d file count", lineNo[idx]), lineWord[idx], cfgRdata, ok);
      report($sformatf("line %0d", lineNo[idx]), ok);
    end
  endtask

  // nothing may leave a full queue before the first grant
  task automatic checkStall();
    bit ok;
    ok = 1'b1;
    instrValid <= 1'b0;
    repeat (12) tick();
    checkValue("stall sender credits", 0, senderCredits, ok);
    checkValue("stall results", 0, resultsReceived, ok);
    checkValue("stall credits back", 0, creditPulses, ok);
    report("back-pressure stall", ok);
    creditsOn <= 1'b1;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // consumer grants and result checking
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin : creditGen
    if (creditsOn && creditGap == 0) begin
      resultCredit <= 1'b1;
      creditGap = $urandom % 4;                 // random spacing of grants
    end else begin
      resultCredit <= 1'b0;
      if (creditGap != 0) creditGap--;
    end
  end

  always @(posedge clk) begin : resultCheck
    int idx;
    bit ok;
    if (rstN && instrCredit) creditPulses++;
    if (rstN && resultValid) begin
      resultsReceived++;
      if (expQueue.size() == 0) begin
        $display("result %h arrived with no instruction outstanding", result);
        errorCount++;
      end else begin
        idx = expQueue.pop_front();             // program order
        ok = 1'b1;
        checkValue($sformatf("line %0d result", lineNo[idx]), lineRes[idx], result, ok);
        checkValue($sformatf("line %0d illegal", lineNo[idx]), 32'(lineIll[idx]),
                   32'(illegal), ok);
        report($sformatf("line %0d", lineNo[idx]), ok);
      end
    end
  end

  initial begin
    bit ok;
    clk          = 1'b0;
    rstN         = 1'b0;
    instrValid   = 1'b0;
    instr        = '0;
    srcA         = '0;
    srcB         = '0;
    resultCredit = 1'b0;
    cfgWrite     = 1'b0;
    cfgAddr      = `CFG_ADDR_ENABLE;
    cfgWdata     = '0;
    void'($urandom(32'h6345));
    loadData();
    repeat (4) @(posedge clk);
    rstN <= 1'b1;
    for (i = 0; i < lineKind.size() && !timedOut; i++) begin
      case (lineKind[i])
        0: begin
          sendInstr(i);
          if (!timedOut && !creditsOn && issuedCount == `BMU_QUEUE_DEPTH) checkStall();
        end
        1: writeEnable(i);
        2: readIllCount(i);
        default: begin
          $display("data line %0d has unknown kind %0d", lineNo[i], lineKind[i]);
          errorCount++;
        end
      endcase
    end
    if (!timedOut) waitDrain();
    if (!timedOut) begin
      ok = 1'b1;
      tick();                                   // last credit back to sender
      checkValue("credits returned", resultsReceived, creditPulses, ok);
      checkValue("sender credits", `BMU_QUEUE_DEPTH, senderCredits, ok);
      checkValue("results received", issuedCount, resultsReceived, ok);
      report("credit balance", ok);
    end
    $display("tests %0d, errors %0d", testCount, errorCount);
    if (errorCount == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: bench/bmu_testdata.txt
// kind word srcA srcB expected illegal; kind and illegal decimal, the rest hex
// kind 0 instruction, 1 write word to enables, 2 read illegal count against word
0 2020A1B3 00001000 00000005 00002005 0  // sh1add
0 2020E1B3 10000001 00000001 80000009 0  // sh3add
0 4020F1B3 FF00FF00 0F0F0F0F F000F000 0  // andn
0 4020C1B3 12345678 0F0F0F0F E2C4A688 0  // xnor
0 0A20C1B3 FFFFFFFF 00000001 FFFFFFFF 0  // min
0 0A20F1B3 80000000 7FFFFFFF 80000000 0  // maxu
0 602091B3 80000001 00000004 00000018 0  // rol
0 6020D1B3 80000001 00000024 18000000 0  // ror, low five bits of srcB
0 6080D193 12345678 00000000 78123456 0  // rori 8
0 60009193 00010000 00000000 0000000F 0  // clz
0 60109193 00010000 00000000 00000010 0  // ctz
0 60209193 F0F00F0F 00000000 00000010 0  // cpop
0 60409193 00000080 00000000 FFFFFF80 0  // sext.b
0 0800C1B3 ABCD1234 00000000 00001234 0  // zext.h
0 6980D193 12345678 00000000 78563412 0  // rev8
0 2870D193 00100080 00000000 00FF00FF 0  // orc.b
0 482091B3 FFFFFFFF 0000001F 7FFFFFFF 0  // bclr
0 282091B3 00000000 00000005 00000020 0  // bset
0 682091B3 000000FF 00000003 000000F7 0  // binv
0 4820D1B3 00000100 00000008 00000001 0  // bext
0 4830D193 00000008 FFFFFFFF 00000001 0  // bexti 3, srcB unused
0 002081B3 00000001 00000002 00000000 1  // add, not bit-manipulation
0 00209193 00000001 00000000 00000000 1  // slli, plain alu shift
2 00000002 00000000 00000000 00000000 0  // illegal count so far
1 00000005 00000000 00000000 00000000 0  // zbb off
0 4020F1B3 12345678 0000FFFF 00000000 1  // andn with zbb off
0 60009193 00010000 00000000 00000000 1  // clz with zbb off
0 2020C1B3 00000010 00000003 00000043 0  // sh2add, zba still on
1 00000007 00000000 00000000 00000000 0  // zbb back on
0 4020F1B3 12345678 0000FFFF 12340000 0  // andn
2 00000004 00000000 00000000 00000000 0  // illegal count at end

// File: design/bmuCfg.sv
////////////////////////////////////////////////////////////////////////////
// bit-manipulation configuration block
// per-extension enables steering the decoder and a saturating count of
// illegal ops reaching the result queue, both readable on cfgRdata
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "bmu_consts.svh"

module bmuCfg import bmuPkg::*; (
  input  logic      clk,
  input  logic      rstN,
  input  logic      cfgWrite,     // write strobe
  input  cfgAddrT   cfgAddr,      // register select
  input  xlenT      cfgWdata,     // write data
  output xlenT      cfgRdata,     // combinational read
  input  logic      illegalSeen,  // illegal op entering queue
  output extEnableT extEnable     // to decoder
);

  logic [`BMU_ILLCOUNT_W-1:0] illCount;  // illegal op count
  logic                       illSat;    // count at max

  assign illSat = &illCount;

  ////////////////////////////////////////////////////////////////////////////
  // extension enables
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) begin
      extEnable <= 3'b111;                       // all extensions on
    end else if (cfgWrite && cfgAddr == `CFG_ADDR_ENABLE) begin
      extEnable <= cfgWdata[2:0];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // illegal counter
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) begin
      illCount <= '0;
    end else if (cfgWrite && cfgAddr == `CFG_ADDR_ILLCOUNT) begin
      illCount <= '0;                            // clear wins over count
    end else if (illegalSeen && !illSat) begin
      illCount <= illCount + 1'b1;               // saturate at all ones
    end
  end

  // read mux, zero extended
  always_comb begin
    case (cfgAddr)
      `CFG_ADDR_ENABLE: cfgRdata = xlenT'(extEnable);
      default:          cfgRdata = xlenT'(illCount);
    endcase
  end

endmodule

// File: design/bmuDecode.sv
////////////////////////////////////////////////////////////////////////////
// bit-manipulation decoder
// classifies rv32 zba, zbb and zbs encodings into a bmuOpT, flags
// unknown or disabled ones as illegal and registers the result onto
// the issue bus
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module bmuDecode import bmuPkg::*; (
  input  logic      clk,
  input  logic      rstN,
  input  logic      instrValid,  // one instruction this cycle
  input  instrT     instr,
  input  xlenT      srcA,
  input  xlenT      srcB,
  input  extEnableT extEnable,   // from config block
  bmuIssueIf.decode issue
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [4:0] rs2;

  bmuOpT      decOp;      // raw table match
  extEnableT  extNeeded;  // one-hot extension of the match, 0 if none
  logic       decImm;     // immediate form
  logic       legal;      // matched and enabled

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rs2    = instr[24:20];

  ////////////////////////////////////////////////////////////////////////////
  // main decode table
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    decOp     = opNone;
    extNeeded = 3'b000;
    decImm    = 1'b0;
    casez ({opcode, funct7, funct3})
      // zbs
      17'b0010011_0100100_001: {decOp, extNeeded, decImm} = {opBclr, 3'b100, 1'b1}; // bclri
      17'b0010011_0100100_101: {decOp, extNeeded, decImm} = {opBext, 3'b100, 1'b1}; // bexti
      17'b0010011_0110100_001: {decOp, extNeeded, decImm} = {opBinv, 3'b100, 1'b1}; // binvi
      17'b0010011_0010100_001: {decOp, extNeeded, decImm} = {opBset, 3'b100, 1'b1}; // bseti
      17'b0110011_0100100_001: {decOp, extNeeded} = {opBclr, 3'b100};       // bclr
      17'b0110011_0100100_101: {decOp, extNeeded} = {opBext, 3'b100};       // bext
      17'b0110011_0110100_001: {decOp, extNeeded} = {opBinv, 3'b100};       // binv
      17'b0110011_0010100_001: {decOp, extNeeded} = {opBset, 3'b100};       // bset
      // zba
      17'b0110011_0010000_010: {decOp, extNeeded} = {opShAdd1, 3'b001};     // sh1add
      17'b0110011_0010000_100: {decOp, extNeeded} = {opShAdd2, 3'b001};     // sh2add
      17'b0110011_0010000_110: {decOp, extNeeded} = {opShAdd3, 3'b001};     // sh3add
      // zbb
      17'b0110011_0110000_001: {decOp, extNeeded} = {opRol, 3'b010};        // rol
      17'b0110011_0110000_101: {decOp, extNeeded} = {opRor, 3'b010};        // ror
      17'b0010011_0110000_101: {decOp, extNeeded, decImm} = {opRor, 3'b010, 1'b1}; // rori
      17'b0010011_0110000_001: begin                   // counts and sign extends
        extNeeded = 3'b010;
        case (rs2)
          5'b00000: decOp = opClz;
          5'b00001: decOp = opCtz;
          5'b00010: decOp = opCpop;
          5'b00100: decOp = opSextB;
          5'b00101: decOp = opSextH;
          default:  extNeeded = 3'b000;                // reserved rs2 code
        endcase
      end
      17'b0110011_0000100_100:                         // zext.h, rs2 must be 0
        if (rs2 == 5'b00000) {decOp, extNeeded} = {opZextH, 3'b010};
      17'b0110011_0100000_111: {decOp, extNeeded} = {opAndn, 3'b010};       // andn
      17'b0110011_0100000_110: {decOp, extNeeded} = {opOrn, 3'b010};        // orn
      17'b0110011_0100000_100: {decOp, extNeeded} = {opXnor, 3'b010};       // xnor
      17'b0010011_0110100_101:                         // rev8 rv32 form only
        if (rs2 == 5'b11000) {decOp, extNeeded} = {opRev8, 3'b010};
      17'b0010011_0010100_101:                         // orc.b
        if (rs2 == 5'b00111) {decOp, extNeeded} = {opOrcB, 3'b010};
      17'b0110011_0000101_100: {decOp, extNeeded} = {opMin, 3'b010};        // min
      17'b0110011_0000101_101: {decOp, extNeeded} = {opMinu, 3'b010};       // minu
      17'b0110011_0000101_110: {decOp, extNeeded} = {opMax, 3'b010};        // max
      17'b0110011_0000101_111: {decOp, extNeeded} = {opMaxu, 3'b010};       // maxu
      default: ;                                       // shifts, alu, zbc: not ours
    endcase
  end

  assign legal = |(extNeeded & extEnable);  // disabled extension reads as illegal

  ////////////////////////////////////////////////////////////////////////////
  // decode pipeline register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) begin
      issue.valid <= 1'b0;
    end else begin
      issue.valid <= instrValid;
    end
  end

  always_ff @(posedge clk) begin
    if (instrValid) begin                      // payload, no reset
      issue.op      <= legal ? decOp : opNone;
      issue.illegal <= ~legal;
      issue.srcA    <= srcA;
      issue.srcB    <= srcB;
      issue.useImm  <= decImm;
      issue.shamt   <= rs2;
    end
  end

endmodule

// File: design/bmuExecute.sv
////////////////////////////////////////////////////////////////////////////
// bit-manipulation execute stage
// computes zba/zbb/zbs results, buffers them in a small circular queue
// and releases one per downstream credit, returning an upstream credit
// as each slot frees
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "bmu_consts.svh"

module bmuExecute import bmuPkg::*; (
  input  logic       clk,
  input  logic       rstN,
  bmuIssueIf.execute issue,
  input  logic       resultCredit,  // consumer grants one slot
  output logic       resultValid,   // one result this cycle
  output xlenT       result,
  output logic       illegal,
  output logic       instrCredit,   // slot freed, back to sender
  output logic       illegalSeen    // to illegal counter
);

  xlenT       opA;      // rs1
  xlenT       opB;      // rs2 or immediate
  logic [4:0] sh;       // shift / bit index
  xlenT       revA;     // opA bit reversed, for ctz
  xlenT       aluRes;

  xlenT                    resMem [`BMU_QUEUE_DEPTH];  // queue payload
  logic                    illMem [`BMU_QUEUE_DEPTH];
  logic [`BMU_QPTR_W-1:0]  wrPtr;
  logic [`BMU_QPTR_W-1:0]  rdPtr;
  logic [`BMU_QCNT_W-1:0]  qCount;   // occupancy
  logic [`BMU_CREDIT_W-1:0] dnCredit; // downstream credits held

  // leading zeros, 0..32
  function automatic logic [5:0] countLead(input xlenT value);
    logic [5:0] n;
    logic       hit;
    n   = '0;
    hit = 1'b0;
    for (int i = `XLEN - 1; i >= 0; i--) begin
      if (value[i]) hit = 1'b1;
      else if (!hit) n = n + 6'd1;
    end
    return n;
  endfunction

  function automatic logic [5:0] countOnes(input xlenT value);
    logic [5:0] n;
    n = '0;
    for (int i = 0; i < `XLEN; i++) n = n + 6'(value[i]);
    return n;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // datapath
  ////////////////////////////////////////////////////////////////////////////

  assign opA  = issue.srcA;
  assign opB  = issue.useImm ? xlenT'(issue.shamt) : issue.srcB;
  assign sh   = opB[4:0];                          // only low 5 bits matter
  assign revA = {<<{opA}};

  always_comb begin
    case (issue.op)
      opShAdd1: aluRes = (opA << 1) + opB;
      opShAdd2: aluRes = (opA << 2) + opB;
      opShAdd3: aluRes = (opA << 3) + opB;
      opAndn:   aluRes = opA & ~opB;
      opOrn:    aluRes = opA | ~opB;
      opXnor:   aluRes = ~(opA ^ opB);
      opMin:    aluRes = ($signed(opA) < $signed(opB)) ? opA : opB;
      opMinu:   aluRes = (opA < opB) ? opA : opB;
      opMax:    aluRes = ($signed(opA) < $signed(opB)) ? opB : opA;
      opMaxu:   aluRes = (opA < opB) ? opB : opA;
      opRol:    aluRes = (opA << sh) | (opA >> (6'd32 - {1'b0, sh}));  // sh 0 gives opA
      opRor:    aluRes = (opA >> sh) | (opA << (6'd32 - {1'b0, sh}));
      opClz:    aluRes = xlenT'(countLead(opA));
      opCtz:    aluRes = xlenT'(countLead(revA));  // trailing = leading of reversed
      opCpop:   aluRes = xlenT'(countOnes(opA));
      opSextB:  aluRes = {{24{opA[7]}}, opA[7:0]};
      opSextH:  aluRes = {{16{opA[15]}}, opA[15:0]};
      opZextH:  aluRes = {16'b0, opA[15:0]};
      opRev8:   aluRes = {opA[7:0], opA[15:8], opA[23:16], opA[31:24]};
      opOrcB:   aluRes = {{8{|opA[31:24]}}, {8{|opA[23:16]}},
                          {8{|opA[15:8]}}, {8{|opA[7:0]}}};
      opBclr:   aluRes = opA & ~(xlenT'(1) << sh);
      opBset:   aluRes = opA | (xlenT'(1) << sh);
      opBinv:   aluRes = opA ^ (xlenT'(1) << sh);
      opBext:   aluRes = xlenT'((opA >> sh) & xlenT'(1));
      default:  aluRes = '0;                       // opNone, illegal
    endcase
  end

  assign illegalSeen = issue.valid & issue.illegal;  // counted as it enters queue

  ////////////////////////////////////////////////////////////////////////////
  // result queue and credits
  ////////////////////////////////////////////////////////////////////////////

  assign resultValid = (dnCredit != '0) && (qCount != '0);
  assign instrCredit = resultValid;                // slot frees as result leaves
  assign result      = resMem[rdPtr];
  assign illegal     = illMem[rdPtr];

  always_ff @(posedge clk) begin
    if (issue.valid) begin                         // always room, sender holds credit
      resMem[wrPtr] <= issue.illegal ? '0 : aluRes;
      illMem[wrPtr] <= issue.illegal;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      wrPtr    <= '0;
      rdPtr    <= '0;
      qCount   <= '0;
      dnCredit <= '0;
    end else begin
      if (issue.valid)
        wrPtr <= (wrPtr == `BMU_QPTR_W'(`BMU_QUEUE_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
      if (resultValid)
        rdPtr <= (rdPtr == `BMU_QPTR_W'(`BMU_QUEUE_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
      qCount <= qCount + `BMU_QCNT_W'(issue.valid) - `BMU_QCNT_W'(resultValid);
      if (resultCredit && !resultValid && !(&dnCredit))
        dnCredit <= dnCredit + 1'b1;               // saturating grant
      else if (!resultCredit && resultValid)
        dnCredit <= dnCredit - 1'b1;
    end
  end

endmodule

// File: design/bmuIssueIf.sv
////////////////////////////////////////////////////////////////////////////
// decode to execute issue bus
// one decoded op per valid cycle; execute never back-pressures because
// the upstream credits guarantee a free queue slot
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface bmuIssueIf import bmuPkg::*; ();

  logic       valid;   // one-cycle qualifier
  bmuOpT      op;      // decoded operation
  logic       illegal; // unrecognized or disabled
  xlenT       srcA;    // rs1 value
  xlenT       srcB;    // rs2 value
  logic       useImm;  // immediate form, use shamt
  logic [4:0] shamt;   // rs2 field / immediate amount

  modport decode (
    output valid,
    output op,
    output illegal,
    output srcA,
    output srcB,
    output useImm,
    output shamt
  );

  modport execute (
    input valid,
    input op,
    input illegal,
    input srcA,
    input srcB,
    input useImm,
    input shamt
  );

endinterface

// File: design/bmuPkg.sv
////////////////////////////////////////////////////////////////////////////
// bit-manipulation unit types
// vector typedefs and the operation encoding shared by decode and execute
////////////////////////////////////////////////////////////////////////////

`include "bmu_consts.svh"

package bmuPkg;

  typedef logic [`XLEN-1:0] xlenT;       // operand and result
  typedef logic [31:0]      instrT;      // raw instruction word
  typedef logic [2:0]       extEnableT;  // bit0 zba, bit1 zbb, bit2 zbs
  typedef logic [0:0]       cfgAddrT;    // config register select

  typedef enum logic [4:0] {
    opShAdd1,                            // zba
    opShAdd2,
    opShAdd3,
    opAndn,                              // zbb logic with inverted operand
    opOrn,
    opXnor,
    opMin,                               // zbb compare
    opMinu,
    opMax,
    opMaxu,
    opRol,                               // zbb rotates
    opRor,
    opClz,                               // zbb counts
    opCtz,
    opCpop,
    opSextB,                             // zbb extends
    opSextH,
    opZextH,
    opRev8,                              // zbb byte ops
    opOrcB,
    opBclr,                              // zbs single bit
    opBset,
    opBinv,
    opBext,
    opNone                               // not a bit-manipulation op
  } bmuOpT;

endpackage

// File: design/bmuTop.sv
////////////////////////////////////////////////////////////////////////////
// bit-manipulation unit top level
// config block, decoder and execute stage joined by the issue bus
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module bmuTop import bmuPkg::*; (
  input  logic    clk,
  input  logic    rstN,
  input  logic    instrValid,    // sender holds a credit
  input  instrT   instr,
  input  xlenT    srcA,
  input  xlenT    srcB,
  output logic    instrCredit,   // one credit back to sender
  output logic    resultValid,
  output xlenT    result,
  output logic    illegal,
  input  logic    resultCredit,  // consumer grants a slot
  input  logic    cfgWrite,
  input  cfgAddrT cfgAddr,
  input  xlenT    cfgWdata,
  output xlenT    cfgRdata
);

  extEnableT extEnable;    // cfg to decode
  logic      illegalSeen;  // execute to cfg

  bmuIssueIf issueBus ();

  bmuCfg uCfg (
    .clk, .rstN,
    .cfgWrite, .cfgAddr, .cfgWdata, .cfgRdata,
    .illegalSeen, .extEnable
  );

  bmuDecode uDecode (
    .clk, .rstN,
    .instrValid, .instr, .srcA, .srcB,
    .extEnable,
    .issue (issueBus.decode)
  );

  bmuExecute uExecute (
    .clk, .rstN,
    .issue (issueBus.execute),
    .resultCredit, .resultValid, .result, .illegal,
    .instrCredit, .illegalSeen
  );

endmodule

// File: design/bmu_consts.svh
////////////////////////////////////////////////////////////////////////////
// bit-manipulation unit constants
// data width, result queue sizing, credit and counter widths and the
// configuration register map
////////////////////////////////////////////////////////////////////////////

`ifndef BMU_CONSTS_SVH
`define BMU_CONSTS_SVH

`define XLEN 32                   // rv32 only

// result queue, also the number of upstream credits after reset
`define BMU_QUEUE_DEPTH 4
`define BMU_QPTR_W 2              // queue pointer bits
`define BMU_QCNT_W 3              // occupancy bits, 0..depth

`define BMU_CREDIT_W 4            // downstream credit counter bits
`define BMU_ILLCOUNT_W 16         // illegal op counter bits

// configuration register map
`define CFG_ADDR_ENABLE 1'b0      // extension enables
`define CFG_ADDR_ILLCOUNT 1'b1    // illegal count, write clears

`endif

// File: list.f
+incdir+design
design/bmuPkg.sv
design/bmuIssueIf.sv
design/bmuCfg.sv
design/bmuDecode.sv
design/bmuExecute.sv
design/bmuTop.sv
bench/bmuTb.sv
